// ==== compile.f ====
hw/mmu_pkg.sv
hw/req_hold.sv
hw/page_walker.sv
hw/axi_engine.sv
hw/mmu_core.sv
verification/tb_clock.sv
verification/tb_axi_memory.sv
verification/tb_mmu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f compile.f --top-module tb_mmu -o tb_mmu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_mmu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" sim.log; then
    exit 0
fi
exit 1

// ==== verification/tb_mmu.sv ====
// ##############################
// directed tests of the MMU
// page tables are written straight into the memory model
// ##############################
`timescale 1ns/1ps
`default_nettype none

module tb_mmu import mmu_pkg::*; ();

    localparam int TIMEOUT = 400;

    logic clk, rst;
    rqst_id_t tr_rqst, tr_resp, dc_rqst, dc_resp;
    addr_t tr_vadd, tr_padd, dc_addr, araddr, awaddr;
    word_t tr_satp, dc_wdat, dc_rdat, rdata, wdata;
    perm_t tr_perm;
    strb_t dc_strb, wstrb;
    logic arvalid, arready, rvalid, rready, awvalid, awready;
    logic wvalid, wready, bvalid, bready;
    int errors = 0;
    int checks = 0;
    logic [31:0] lfsr = 32'hc2a71e0b;

    tb_clock i_clk (.clk(clk), .rst(rst));

    mmu_core i_dut (.*);

    tb_axi_memory i_mem (.*);

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b)
                lfsr = lfsr ^ 32'h80200003;
            r = {r[62:0], b};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
    endtask

    task automatic check_idle();
        check("tr_resp", tr_resp, 0);
        check("dc_resp", dc_resp, 0);
        check("arvalid", arvalid, 0);
        check("awvalid", awvalid, 0);
    endtask

    function automatic addr_t pte_addr(input ppn_t ppn, input addr_t va, input int lvl);
        return (addr_t'(ppn) << 12) + (((va >> (12 + 9 * lvl)) & 64'h1ff) << 3);
    endfunction

    // chain of pointer entries ending in one leaf entry
    task automatic build_table(input ppn_t root, input addr_t va, input int levels,
                               input int leaf_lvl, input ppn_t leaf_ppn, input perm_t low);
        ppn_t cur;
        cur = root;
        for (int l = levels - 1; l > leaf_lvl; l--) begin
            i_mem.poke(pte_addr(cur, va, l), (word_t'(cur + 1) << 10) | 64'h1);
            cur = cur + 1;
        end
        i_mem.poke(pte_addr(cur, va, leaf_lvl), (word_t'(leaf_ppn) << 10) | word_t'(low));
    endtask

    task automatic translate(input rqst_id_t id, input addr_t va, input word_t satp,
                             output perm_t perm, output addr_t padd);
        int n;
        @(posedge clk);
        tr_rqst <= id;
        tr_vadd <= va;
        tr_satp <= satp;
        @(posedge clk);
        tr_rqst <= '0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clk);
            if (tr_resp == id) begin
                perm = tr_perm;
                padd = tr_padd;
                break;
            end
        end
        if (n == TIMEOUT)
            report_timeout("tr_resp");
    endtask

    task automatic data_access(input rqst_id_t id, input addr_t a, input strb_t s,
                               input word_t wd, output word_t rd);
        int n;
        @(posedge clk);
        dc_rqst <= id;
        dc_addr <= a;
        dc_strb <= s;
        dc_wdat <= wd;
        @(posedge clk);
        dc_rqst <= '0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clk);
            if (dc_resp == id) begin
                rd = dc_rdat;
                break;
            end
        end
        if (n == TIMEOUT)
            report_timeout("dc_resp");
    endtask

    task automatic test_reset();
        int n;
        @(posedge clk);                 // first edge applies reset
        for (n = 0; n < 20 && rst; n++) begin
            @(posedge clk);
            check_idle();
        end
        if (rst)
            report_timeout("reset release");
        repeat (4) begin                // idle until the first request
            @(posedge clk);
            check_idle();
        end
    endtask

    task automatic test_data();
        word_t old, wd, rd, exp;
        strb_t s;
        int wc;
        addr_t a;
        wc = i_mem.write_count;
        data_access(8'h20, 64'h1000_0040, '0, '0, rd);
        check("dc_rdat", rd, i_mem.peek(64'h1000_0040));
        check("write_count", i_mem.write_count, wc);
        for (int k = 0; k < 4; k++) begin
            a = 64'h1000_0000 + (rand_bits(8) << 3);
            old = rand_bits(64);
            wd = rand_bits(64);
            s = strb_t'(rand_bits(8)) | 8'h01;
            i_mem.poke(a, old);
            wc = i_mem.write_count;
            exp = old;
            for (int i = 0; i < 8; i++)
                if (s[i])
                    exp[8*i +: 8] = wd[8*i +: 8];
            data_access(8'h21 + 8'(k), a, s, wd, rd);
            check("dc_rdat", rd, old);
            check("write_count", i_mem.write_count, wc + 1);
            data_access(8'h30 + 8'(k), a, '0, '0, rd);
            check("dc_rdat", rd, exp);
        end
    endtask

    task automatic test_walks();
        perm_t perm;
        addr_t padd;
        addr_t va;
        va = 64'h0000_0045_6789_a000;
        build_table(44'h80000, va, 3, 0, 44'h12345, 8'hcf);
        translate(8'h40, va, {SATP_SV39, 16'h0, 44'h80000}, perm, padd);
        check("tr_perm", perm, 8'hcf);
        check("tr_padd", padd, 64'h12345 << 12);
        va = 64'h0000_9a45_6789_a000;
        build_table(44'h81000, va, 4, 0, 44'h23456, 8'hcb);
        translate(8'h41, va, {SATP_SV48, 16'h0, 44'h81000}, perm, padd);
        check("tr_perm", perm, 8'hcb);
        check("tr_padd", padd, 64'h23456 << 12);
        // 2 MiB leaf at level 1
        va = 64'h0000_0012_3456_7000;
        build_table(44'h82000, va, 3, 1, 44'h34600, 8'hc7);
        translate(8'h42, va, {SATP_SV39, 16'h0, 44'h82000}, perm, padd);
        check("tr_perm", perm, 8'hc7);
        check("tr_padd", padd, (64'h34600 << 12) | {43'h0, va[20:12], 12'h0});
        build_table(44'h83000, va, 3, 1, 44'h34601, 8'hc7);
        translate(8'h43, va, {SATP_SV39, 16'h0, 44'h83000}, perm, padd);
        check("tr_perm", perm, 0);
        translate(8'h44, va, {4'h0, 16'h0, 44'h83000}, perm, padd);
        check("tr_perm", perm, 0);
        // V clear on an otherwise aligned 1 GiB leaf
        i_mem.poke(pte_addr(44'h84000, va, 2), 64'h0000_0000_1000_00ce);
        translate(8'h45, va, {SATP_SV39, 16'h0, 44'h84000}, perm, padd);
        check("tr_perm", perm, 0);
    endtask

    initial begin
        tr_rqst = '0;
        tr_vadd = '0;
        tr_satp = '0;
        dc_rqst = '0;
        dc_addr = '0;
        dc_strb = '0;
        dc_wdat = '0;
        test_reset();
        test_data();
        test_walks();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_axi_memory.sv ====
// ##############################
// sparse AXI slave memory for single beats only
// ready and valid stall at random from an LFSR
// unwritten words read as a pattern of their address
// ##############################
`timescale 1ns/1ps
`default_nettype none

module tb_axi_memory import mmu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output word_t rdata,
    output logic  rvalid,
    input  logic  rready,
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  word_t wdata,
    input  strb_t wstrb,
    input  logic  wvalid,
    output logic  wready,
    output logic  bvalid,
    input  logic  bready
);

    word_t       mem [logic [60:0]];    // indexed by word address
    int          write_count = 0;
    logic [31:0] lfsr = 32'hc2a71e0b;
    addr_t       ar_addr;
    addr_t       aw_addr;
    logic        r_pend;
    logic        aw_pend;

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h80200003;
        return b;
    endfunction

    function automatic word_t peek(input addr_t a);
        if (mem.exists(a[63:3]))
            return mem[a[63:3]];
        return ~a ^ {a[31:0], a[63:32]};  // fill depends on every bit
    endfunction

    task automatic poke(input addr_t a, input word_t d);
        mem[a[63:3]] = d;
    endtask

    initial begin                       // quiet until the first reset edge
        arready = 1'b0;
        rdata   = '0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
    end

    always @(posedge clk) begin
        logic s_ar;
        logic s_r;
        logic s_aw;
        logic s_w;
        word_t merged;
        s_ar = lfsr_bit();
        s_r  = lfsr_bit();
        s_aw = lfsr_bit();
        s_w  = lfsr_bit();
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            r_pend  <= 1'b0;
            aw_pend <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                ar_addr <= araddr;
                arready <= 1'b0;
                r_pend  <= 1'b1;
            end else if (!r_pend && !rvalid) begin
                arready <= s_ar;
            end
            if (r_pend && s_r) begin
                rvalid <= 1'b1;
                rdata  <= peek(ar_addr);
                r_pend <= 1'b0;
            end
            if (rvalid && rready)
                rvalid <= 1'b0;
            if (awvalid && awready) begin
                aw_addr <= awaddr;
                awready <= 1'b0;
                aw_pend <= 1'b1;
            end else if (!aw_pend && !bvalid) begin
                awready <= s_aw;
            end
            if (wvalid && wready) begin
                merged = peek(aw_addr);
                for (int i = 0; i < 8; i++)
                    if (wstrb[i])
                        merged[8*i +: 8] = wdata[8*i +: 8];
                mem[aw_addr[63:3]] = merged;
                write_count++;
                wready  <= 1'b0;
                aw_pend <= 1'b0;
                bvalid  <= 1'b1;
            end else if (aw_pend) begin
                wready <= s_w;
            end
            if (bvalid && bready)
                bvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
// ##############################
// testbench clock and reset
// 20 ns period, reset high for 8 cycles
// ##############################
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;                    // released on the edge
    end

endmodule

`default_nettype wire

// ==== hw/mmu_core.sv ====
// ##############################
// MMU top, request hold then walker then AXI engine
// every data access is uncached and single beat
// ##############################
`timescale 1ns/1ps
`default_nettype none

module mmu_core import mmu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  rqst_id_t tr_rqst,
    input  addr_t    tr_vadd,
    input  word_t    tr_satp,
    output rqst_id_t tr_resp,
    output perm_t    tr_perm,
    output addr_t    tr_padd,
    input  rqst_id_t dc_rqst,
    input  addr_t    dc_addr,
    input  strb_t    dc_strb,
    input  word_t    dc_wdat,
    output rqst_id_t dc_resp,
    output word_t    dc_rdat,
    output addr_t    araddr,
    output logic     arvalid,
    input  logic     arready,
    input  word_t    rdata,
    input  logic     rvalid,
    output logic     rready,
    output addr_t    awaddr,
    output logic     awvalid,
    input  logic     awready,
    output word_t    wdata,
    output strb_t    wstrb,
    output logic     wvalid,
    input  logic     wready,
    input  logic     bvalid,
    output logic     bready
);

    rqst_id_t tr_held_rqst;
    word_t    tr_held_vadd;
    word_t    tr_held_satp;

    rqst_id_t dc_held_rqst;
    word_t    dc_held_addr;
    word_t    dc_held_wdat;
    strb_t    dc_held_strb;

    logic     rd_req;       // walker PTE read
    addr_t    rd_addr;
    logic     rd_done;
    word_t    rd_data;

    req_hold i_tr_hold (
        .clk       (clk),
        .rst       (rst),
        .rqst      (tr_rqst),
        .op_a      (tr_vadd),
        .op_b      (tr_satp),
        .op_strb   ('0),            // no strobe on translation
        .resp      (tr_resp),
        .held_rqst (tr_held_rqst),
        .held_a    (tr_held_vadd),
        .held_b    (tr_held_satp),
        .held_strb ()
    );

    req_hold i_dc_hold (
        .clk       (clk),
        .rst       (rst),
        .rqst      (dc_rqst),
        .op_a      (dc_addr),
        .op_b      (dc_wdat),
        .op_strb   (dc_strb),
        .resp      (dc_resp),
        .held_rqst (dc_held_rqst),
        .held_a    (dc_held_addr),
        .held_b    (dc_held_wdat),
        .held_strb (dc_held_strb)
    );

    page_walker i_walker (
        .clk       (clk),
        .rst       (rst),
        .held_rqst (tr_held_rqst),
        .vadd      (tr_held_vadd),
        .satp      (tr_held_satp),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_done   (rd_done),
        .rd_data   (rd_data),
        .tr_resp   (tr_resp),
        .tr_perm   (tr_perm),
        .tr_padd   (tr_padd)
    );

    axi_engine i_engine (
        .clk       (clk),
        .rst       (rst),
        .held_rqst (dc_held_rqst),
        .addr      (dc_held_addr),
        .wdat      (dc_held_wdat),
        .strb      (dc_held_strb),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_done   (rd_done),
        .rd_data   (rd_data),
        .dc_resp   (dc_resp),
        .dc_rdat   (dc_rdat),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .rready    (rready),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

endmodule

`default_nettype wire

// ==== hw/axi_engine.sv ====
// ##############################
// single-beat AXI engine, read then optional write
// a held data request goes before a walker read
// a started transaction always runs to the end
// ##############################
`timescale 1ns/1ps
`default_nettype none

module axi_engine import mmu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  rqst_id_t held_rqst,
    input  word_t    addr,
    input  word_t    wdat,
    input  strb_t    strb,
    input  logic     rd_req,
    input  addr_t    rd_addr,
    output logic     rd_done,
    output word_t    rd_data,
    output rqst_id_t dc_resp,
    output word_t    dc_rdat,
    output addr_t    araddr,
    output logic     arvalid,
    input  logic     arready,
    input  word_t    rdata,
    input  logic     rvalid,
    output logic     rready,
    output addr_t    awaddr,
    output logic     awvalid,
    input  logic     awready,
    output word_t    wdata,
    output strb_t    wstrb,
    output logic     wvalid,
    input  logic     wready,
    input  logic     bvalid,
    output logic     bready
);

    bus_state_t state;
    rqst_id_t   cur_id;     // WALK_ID for walker reads
    word_t      rd_word;    // word read before any write

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= BS_IDLE;
            cur_id  <= '0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else begin
            case (state)
                BS_IDLE: begin
                    if (held_rqst != '0) begin
                        cur_id  <= held_rqst;
                        araddr  <= addr;
                        wdata   <= wdat;
                        wstrb   <= strb;
                        arvalid <= 1'b1;
                        state   <= BS_AR;
                    end else if (rd_req) begin
                        cur_id  <= WALK_ID;
                        araddr  <= rd_addr;
                        wstrb   <= '0;          // read only
                        arvalid <= 1'b1;
                        state   <= BS_AR;
                    end
                end
                BS_AR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= BS_R;
                    end
                end
                BS_R: begin
                    if (rvalid) begin
                        rready  <= 1'b0;
                        rd_word <= rdata;
                        if (wstrb != '0) begin
                            awaddr  <= araddr;  // same word
                            awvalid <= 1'b1;
                            state   <= BS_AW;
                        end else begin
                            state <= BS_DONE;
                        end
                    end
                end
                BS_AW: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b1;
                        state   <= BS_W;
                    end
                end
                BS_W: begin
                    if (wready) begin
                        wvalid <= 1'b0;
                        bready <= 1'b1;
                        state  <= BS_B;
                    end
                end
                BS_B: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        state  <= BS_DONE;
                    end
                end
                BS_DONE: begin
                    state <= BS_IDLE;
                end
                default: state <= BS_IDLE;
            endcase
        end
    end

    assign rd_done = (state == BS_DONE) && (cur_id == WALK_ID);
    assign dc_resp = (state == BS_DONE && cur_id != WALK_ID) ? cur_id : '0;
    assign rd_data = rd_word;
    assign dc_rdat = rd_word;

    // valid with stable payload until the slave takes it
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)));

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr)));

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        (wvalid && !wready) |=> (wvalid && $stable(wdata) && $stable(wstrb)));

endmodule

`default_nettype wire

// ==== hw/page_walker.sv ====
// ##############################
// Sv39/Sv48/Sv57 page table walker
// one walk at a time over the bus with no TLB
// an unknown SATP mode answers with perm zero
// ##############################
`timescale 1ns/1ps
`default_nettype none

module page_walker import mmu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  rqst_id_t held_rqst,
    input  word_t    vadd,
    input  word_t    satp,
    output logic     rd_req,
    output addr_t    rd_addr,
    input  logic     rd_done,
    input  word_t    rd_data,
    output rqst_id_t tr_resp,
    output perm_t    tr_perm,
    output addr_t    tr_padd
);

    walk_state_t state;
    rqst_id_t    id;          // request being walked
    vpn_t [4:0]  vpn;
    ppn_t        ppn;
    word_t       pte;
    perm_t       perm;
    logic [2:0]  lvl;         // current level counting down
    logic        bad_mode;

    ppn_t        leaf_ppn;    // PPN with superpage slices filled in
    logic        misaligned;

    // low PPN slices of a superpage leaf must be zero and take the VPN
    always_comb begin
        leaf_ppn   = pte[53:10];
        misaligned = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (i < int'(lvl)) begin
                if (pte[10 + i*9 +: 9] != '0)
                    misaligned = 1'b1;
                leaf_ppn[i*9 +: 9] = vpn[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WS_IDLE;
            id    <= '0;
        end else begin
            case (state)
                WS_IDLE: begin
                    if (held_rqst != '0) begin   // held ID is gone the cycle after tr_resp
                        id       <= held_rqst;
                        vpn      <= vadd[56:12];
                        ppn      <= satp[43:0];
                        perm     <= '0;
                        bad_mode <= 1'b0;
                        case (satp[63:60])
                            SATP_SV39: lvl <= 3'd2;
                            SATP_SV48: lvl <= 3'd3;
                            SATP_SV57: lvl <= 3'd4;
                            default:   bad_mode <= 1'b1;
                        endcase
                        state <= WS_ADDR;
                    end
                end
                WS_ADDR: begin
                    rd_addr <= (addr_t'(ppn) << PAGE_SHIFT) | (addr_t'(vpn[lvl]) << 3);
                    state   <= bad_mode ? WS_DONE : WS_WAIT;
                end
                WS_WAIT: begin
                    if (rd_done) begin
                        pte   <= rd_data;
                        state <= WS_EVAL;
                    end
                end
                WS_EVAL: begin
                    if (!pte[PTE_V]) begin
                        state <= WS_DONE;                // invalid entry leaves perm zero
                    end else if (pte[PTE_R] || pte[PTE_X]) begin
                        ppn   <= leaf_ppn;
                        perm  <= misaligned ? perm_t'(0) : pte[7:0];
                        state <= WS_DONE;
                    end else if (lvl == 3'd0) begin
                        state <= WS_DONE;                // pointer at the last level
                    end else begin
                        ppn   <= pte[53:10];
                        lvl   <= lvl - 3'd1;
                        state <= WS_ADDR;
                    end
                end
                WS_DONE: begin
                    state <= WS_IDLE;
                end
                default: state <= WS_IDLE;
            endcase
        end
    end

    assign rd_req  = (state == WS_WAIT);
    assign tr_resp = (state == WS_DONE) ? id : '0;
    assign tr_perm = perm;
    assign tr_padd = addr_t'(ppn) << PAGE_SHIFT;

    // a response always answers the request still held upstream
    a_resp_held: assert property (@(posedge clk) disable iff (rst)
        (tr_resp != '0) |-> (state == WS_DONE && held_rqst == tr_resp));

endmodule

`default_nettype wire

// ==== hw/req_hold.sv ====
// ##############################
// holds one request until its response ID returns
// new pulses are only taken while empty
// ##############################
`timescale 1ns/1ps
`default_nettype none

module req_hold import mmu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  rqst_id_t rqst,
    input  word_t    op_a,
    input  word_t    op_b,
    input  strb_t    op_strb,
    input  rqst_id_t resp,
    output rqst_id_t held_rqst,
    output word_t    held_a,
    output word_t    held_b,
    output strb_t    held_strb
);

    logic empty;

    assign empty = (held_rqst == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            held_rqst <= '0;
        end else if (empty) begin
            held_rqst <= rqst;          // zero keeps it empty
        end else if (resp == held_rqst) begin
            held_rqst <= '0;            // answered
        end
    end

    always_ff @(posedge clk) begin
        if (empty) begin
            held_a    <= op_a;
            held_b    <= op_b;
            held_strb <= op_strb;
        end
    end

    // downstream stages read the operands over many cycles
    a_operands_stable: assert property (@(posedge clk) disable iff (rst)
        (held_rqst != '0 && $past(held_rqst) != '0)
            |-> ($stable(held_a) && $stable(held_b) && $stable(held_strb)));

endmodule

`default_nettype wire

// ==== hw/mmu_pkg.sv ====
// ##############################
// shared widths, types and constants of the MMU
// 64-bit data path, Sv39/Sv48/Sv57 only
// request ID 8'h01 is kept for the walker
// ##############################
`default_nettype none

package mmu_pkg;

    typedef logic [7:0]  rqst_id_t;  // zero means no request
    typedef logic [63:0] addr_t;     // virtual or physical
    typedef logic [63:0] word_t;     // data, SATP and PTE values
    typedef logic [7:0]  strb_t;     // byte write strobe
    typedef logic [7:0]  perm_t;     // low PTE byte, zero on fault
    typedef logic [43:0] ppn_t;
    typedef logic [8:0]  vpn_t;      // one VPN slice

    // SATP mode field, satp[63:60]
    localparam logic [3:0] SATP_SV39 = 4'd8;
    localparam logic [3:0] SATP_SV48 = 4'd9;
    localparam logic [3:0] SATP_SV57 = 4'd10;

    localparam int PTE_V = 0;  // valid
    localparam int PTE_R = 1;  // readable
    localparam int PTE_X = 3;  // executable

    localparam int PAGE_SHIFT = 12;  // 4 KiB pages

    localparam rqst_id_t WALK_ID = 8'h01;  // walker tag on the bus

    typedef enum logic [2:0] {
        WS_IDLE,
        WS_ADDR,  // form the PTE address
        WS_WAIT,  // PTE read on the bus
        WS_EVAL,  // decode the PTE
        WS_DONE   // response cycle
    } walk_state_t;

    typedef enum logic [2:0] {
        BS_IDLE,
        BS_AR,
        BS_R,
        BS_AW,
        BS_W,
        BS_B,
        BS_DONE   // response cycle
    } bus_state_t;

endpackage

`default_nettype wire
